//--- build.f
+incdir+.
gpu_pkg.sv
elastic_buffer.sv
dispatch.sv
alu_unit.sv
sfu_unit.sv
commit_arbiter.sv
exec_core.sv
exec_core_properties.sv
tb_exec_core.sv

//--- tb_exec_core.sv
// ****************************************
// Random and directed test of exec_core
// Fewer than 256 issues so uuids never wrap
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defs.svh"

module tb_exec_core import gpu_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int READY_HIGH  = 0;
    localparam int READY_RAND  = 1;
    localparam int READY_LOW   = 2;
    localparam int ACCEPT_WAIT = 200;
    localparam int DRAIN_WAIT  = 500;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    uuid_t     in_uuid;
    ex_type_e  in_ex_type;
    op_e       in_op;
    tmask_t    in_tmask;
    reg_t      in_rd;
    lane_vec_t in_rs1;
    lane_vec_t in_rs2;
    logic      out_valid;
    logic      out_ready;
    uuid_t     out_uuid;
    reg_t      out_rd;
    tmask_t    out_tmask;
    lane_vec_t out_data;
    perf_ctr_t perf_stalls_alu;
    perf_ctr_t perf_stalls_sfu;

    // Scoreboard indexed by uuid
    lane_vec_t exp_data [256];
    reg_t      exp_rd [256];
    tmask_t    exp_mask [256];
    ex_type_e  exp_unit [256];
    bit        pending [256];
    bit        lat_check [256];
    time       accept_time [256];
    uuid_t     alu_order [$];
    uuid_t     sfu_order [$];

    logic [31:0] rng = 32'h70717508;
    int          ready_mode = READY_HIGH;
    int          outstanding = 0;
    uuid_t       next_uuid = '0;
    perf_ctr_t   tb_stalls_alu = '0;
    perf_ctr_t   tb_stalls_sfu = '0;

    exec_core UUT (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_uuid         (in_uuid),
        .in_ex_type      (in_ex_type),
        .in_op           (in_op),
        .in_tmask        (in_tmask),
        .in_rd           (in_rd),
        .in_rs1          (in_rs1),
        .in_rs2          (in_rs2),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_uuid        (out_uuid),
        .out_rd          (out_rd),
        .out_tmask       (out_tmask),
        .out_data        (out_data),
        .perf_stalls_alu (perf_stalls_alu),
        .perf_stalls_sfu (perf_stalls_sfu)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper halves of two steps since the low LCG bits are weak
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        rng = lcg_next(rng);
        hi = rng[31:16];
        rng = lcg_next(rng);
        return {hi, rng[31:16]};
    endfunction

    // Some lanes forced to zero so vote-any sees both outcomes
    function automatic lane_vec_t rand_lanes();
        lane_vec_t   v;
        logic [31:0] r;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            r = rand32();
            if (r[3:0] < 4'd3) begin
                v[i*`XLEN +: `XLEN] = '0;
            end else begin
                v[i*`XLEN +: `XLEN] = rand32();
            end
        end
        return v;
    endfunction

    // Expected lanes straight from the per-unit rules
    function automatic lane_vec_t model_result(input ex_type_e t, input op_e op,
                                               input tmask_t m, input lane_vec_t a,
                                               input lane_vec_t b);
        lane_vec_t        r;
        logic [`XLEN-1:0] x;
        logic [`XLEN-1:0] y;
        logic [`XLEN-1:0] w;
        int               top;
        int               cnt;
        bit               any;
        r = '0;
        top = 0;
        cnt = 0;
        any = 1'b0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            if (m[i]) begin
                top = i;
                cnt++;
                if (a[i*`XLEN +: `XLEN] != '0) begin
                    any = 1'b1;
                end
            end
        end
        for (int i = 0; i < `NUM_THREADS; i++) begin
            x = a[i*`XLEN +: `XLEN];
            y = b[i*`XLEN +: `XLEN];
            w = '0;
            if (t == EX_ALU) begin
                case (op)
                    OP_ADD: w = x + y;
                    OP_SUB: w = x - y;
                    OP_AND: w = x & y;
                    OP_OR:  w = x | y;
                    OP_XOR: w = x ^ y;
                    OP_SLT: w = ($signed(x) < $signed(y)) ? 1 : 0;
                    default: w = '0;
                endcase
            end else begin
                case (op)
                    OP_BCAST_LAST: w = a[top*`XLEN +: `XLEN];
                    OP_POPC:       w = cnt;
                    OP_VOTE_ANY:   w = any ? 1 : 0;
                    default:       w = '0;
                endcase
            end
            if (m[i]) begin
                r[i*`XLEN +: `XLEN] = w;
            end
        end
        return r;
    endfunction

    task automatic fail_stop();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic uuid_check(input uuid_t got, input uuid_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic rd_check(input reg_t got, input reg_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic mask_check(input tmask_t got, input tmask_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic data_check(input lane_vec_t got, input lane_vec_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic counter_check(input perf_ctr_t got, input perf_ctr_t exp,
                                 input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // One falling edge with out_ready set by the current mode
    task automatic step_cycle();
        logic [31:0] r;
        @(negedge clk);
        case (ready_mode)
            READY_HIGH: out_ready = 1'b1;
            READY_RAND: begin
                r = rand32();
                out_ready = (r[31:30] != 2'b00);
            end
            default: out_ready = 1'b0;
        endcase
    endtask

    task automatic idle_cycle();
        step_cycle();
        in_valid = 1'b0;
    endtask

    task automatic record_issue(input ex_type_e t, input op_e op, input tmask_t m,
                                input lane_vec_t a, input lane_vec_t b, input reg_t rd,
                                input bit timed);
        if (pending[next_uuid]) begin
            $display("uuid %0d reissued while still in flight", next_uuid);
            fail_stop();
        end
        exp_data[next_uuid] = model_result(t, op, m, a, b);
        exp_rd[next_uuid] = rd;
        exp_mask[next_uuid] = m;
        exp_unit[next_uuid] = t;
        pending[next_uuid] = 1'b1;
        lat_check[next_uuid] = timed;
        accept_time[next_uuid] = $time;
        if (t == EX_ALU) begin
            alu_order.push_back(next_uuid);
        end else begin
            sfu_order.push_back(next_uuid);
        end
        outstanding++;
        next_uuid++;
    endtask

    // Returns at the rising edge of acceptance, or after limit stalled edges
    task automatic issue(input ex_type_e t, input op_e op, input tmask_t m,
                         input lane_vec_t a, input lane_vec_t b, input reg_t rd,
                         input bit timed, input int limit, output bit accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        step_cycle();
        in_valid = 1'b1;
        in_uuid = next_uuid;
        in_ex_type = t;
        in_op = op;
        in_tmask = m;
        in_rd = rd;
        in_rs1 = a;
        in_rs2 = b;
        while (!accepted && waited < limit) begin
            @(posedge clk);
            if (in_ready) begin
                record_issue(t, op, m, a, b, rd, timed);
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited < limit) begin
                    step_cycle();
                end
            end
        end
    endtask

    task automatic send(input ex_type_e t, input op_e op, input tmask_t m,
                        input lane_vec_t a, input lane_vec_t b, input reg_t rd,
                        input bit timed);
        bit ok;
        issue(t, op, m, a, b, rd, timed, ACCEPT_WAIT, ok);
        if (!ok) begin
            $display("timeout: instruction uuid %0d was never accepted", next_uuid);
            fail_stop();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (outstanding != 0) begin
            if (waited == DRAIN_WAIT) begin
                $display("timeout: %0d results never reached the output", outstanding);
                fail_stop();
            end
            idle_cycle();
            waited++;
        end
    endtask

    // Stall cycles as the DUT should count them
    always @(posedge clk) begin
        if (!reset && in_valid && !in_ready) begin
            if (in_ex_type == EX_ALU) begin
                tb_stalls_alu <= tb_stalls_alu + perf_ctr_t'(1);
            end else begin
                tb_stalls_sfu <= tb_stalls_sfu + perf_ctr_t'(1);
            end
        end
    end

    always @(posedge clk) begin : result_check
        uuid_t id;
        if (!reset && out_valid && out_ready) begin
            id = out_uuid;
            if (!pending[id]) begin
                $display("result for uuid %0d was not expected or came twice", id);
                fail_stop();
            end
            if (exp_unit[id] == EX_ALU) begin
                uuid_check(id, alu_order.pop_front(), "ALU result order");
            end else begin
                uuid_check(id, sfu_order.pop_front(), "SFU result order");
            end
            rd_check(out_rd, exp_rd[id], "out_rd");
            mask_check(out_tmask, exp_mask[id], "out_tmask");
            data_check(out_data, exp_data[id], "out_data");
            if (lat_check[id] && ($time - accept_time[id] != 3 * CLK_PERIOD)) begin
                $display("ERR @%0t: uuid %0d latency %0t expected %0d", $time, id,
                         $time - accept_time[id], 3 * CLK_PERIOD);
                fail_stop();
            end
            pending[id] = 1'b0;
            outstanding--;
        end
    end

    // Handshake assertion failures end the run at once
    always @(negedge clk) begin
        if (UUT.props.assert_errors != 0) begin
            $display("%0d handshake assertion failures", UUT.props.assert_errors);
            fail_stop();
        end
    end

    initial begin
        int          n;
        bit          accepted;
        bit          stalled;
        logic [31:0] r;
        ex_type_e    t;
        op_e         op;
        tmask_t      m;
        lane_vec_t   a;
        lane_vec_t   b;
        reg_t        rd;
        perf_ctr_t   sfu_before;
        op_e         sfu_ops [3];
        tmask_t      sfu_masks [4];
        reset = 1'b1;
        in_valid = 1'b0;
        in_uuid = '0;
        in_ex_type = EX_ALU;
        in_op = OP_ADD;
        in_tmask = '0;
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        out_ready = 1'b0;
        sfu_ops[0] = OP_BCAST_LAST;
        sfu_ops[1] = OP_POPC;
        sfu_ops[2] = OP_VOTE_ANY;
        sfu_masks[1] = 4'b0100;
        sfu_masks[2] = 4'b0000;
        sfu_masks[3] = 4'b1111;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        step_cycle();
        if (out_valid !== 1'b0) begin
            $display("ERR @%0t: out_valid is %b after reset, expected 0", $time, out_valid);
            fail_stop();
        end
        counter_check(perf_stalls_alu, '0, "ALU stall counter after reset");
        counter_check(perf_stalls_sfu, '0, "SFU stall counter after reset");

        // ALU ops one at a time, random then full mask
        for (n = 0; n < 12; n++) begin
            r = rand32();
            m = (n < 6) ? tmask_t'(r[31:28]) : 4'b1111;
            a = rand_lanes();
            b = rand_lanes();
            rd = reg_t'(r[4:0]);
            send(EX_ALU, op_e'(n % 6), m, a, b, rd, 1'b1);
            wait_drain();
        end

        // SFU ops over random, single-lane, empty and full masks
        for (n = 0; n < 12; n++) begin
            r = rand32();
            sfu_masks[0] = tmask_t'(r[31:28]);
            a = rand_lanes();
            b = rand_lanes();
            send(EX_SFU, sfu_ops[n % 3], sfu_masks[n / 3], a, b, reg_t'(r[4:0]), 1'b1);
            wait_drain();
        end
        send(EX_SFU, OP_VOTE_ANY, 4'b1111, '0, rand_lanes(), 5'd7, 1'b1);
        wait_drain();

        // Random mix under random back-pressure
        ready_mode = READY_RAND;
        for (n = 0; n < 150; n++) begin
            r = rand32();
            if (r[31:30] == 2'b00) begin
                idle_cycle();
            end
            t = r[20] ? EX_SFU : EX_ALU;
            op = (t == EX_ALU) ? op_e'(r[15:8] % 6) : sfu_ops[r[15:8] % 3];
            m = tmask_t'(r[27:24]);
            a = rand_lanes();
            b = rand_lanes();
            send(t, op, m, a, b, reg_t'(r[4:0]), 1'b0);
        end
        wait_drain();

        // Output held low until ALU issue backs up
        ready_mode = READY_HIGH;
        wait_drain();
        counter_check(perf_stalls_alu, tb_stalls_alu, "ALU stall counter before stall test");
        sfu_before = perf_stalls_sfu;
        ready_mode = READY_LOW;
        stalled = 1'b0;
        for (n = 0; n < 10 && !stalled; n++) begin
            r = rand32();
            op = op_e'(r[15:8] % 6);
            m = tmask_t'(r[27:24]);
            a = rand_lanes();
            b = rand_lanes();
            rd = reg_t'(r[4:0]);
            issue(EX_ALU, op, m, a, b, rd, 1'b0, 20, accepted);
            stalled = !accepted;
        end
        if (!stalled) begin
            $display("in_ready never dropped while out_ready was held low");
            fail_stop();
        end
        step_cycle();
        counter_check(perf_stalls_alu, tb_stalls_alu, "ALU stall counter while stalled");
        counter_check(perf_stalls_sfu, sfu_before, "SFU stall counter while ALU stalled");
        ready_mode = READY_HIGH;
        send(EX_ALU, op, m, a, b, rd, 1'b0);
        wait_drain();
        counter_check(perf_stalls_alu, tb_stalls_alu, "ALU stall counter at end");
        counter_check(perf_stalls_sfu, tb_stalls_sfu, "SFU stall counter at end");

        if (UUT.props.assert_errors == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d handshake assertion failures", UUT.props.assert_errors);
            fail_stop();
        end
    end

endmodule

`default_nettype wire

//--- exec_core_properties.sv
// ****************************************
// Handshake assertions on exec_core ports
// Bound into every exec_core instance
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module exec_core_properties import gpu_pkg::*; (
    input wire            clk,
    input wire            reset,
    input wire            in_valid,
    input wire            in_ready,
    input wire uuid_t     in_uuid,
    input wire ex_type_e  in_ex_type,
    input wire op_e       in_op,
    input wire tmask_t    in_tmask,
    input wire reg_t      in_rd,
    input wire lane_vec_t in_rs1,
    input wire lane_vec_t in_rs2,
    input wire            out_valid,
    input wire            out_ready,
    input wire uuid_t     out_uuid,
    input wire reg_t      out_rd,
    input wire tmask_t    out_tmask,
    input wire lane_vec_t out_data
);

    // Failure count, read by the testbench at the end of the run
    int assert_errors = 0;

    // Writeback payload frozen while the port is stalled
    out_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_uuid) && $stable(out_rd)
            && $stable(out_tmask) && $stable(out_data)))
        else begin
            assert_errors++;
            $error("out payload changed while out_ready was low");
        end

    // Issue side obeys the same rule
    in_hold: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_uuid) && $stable(in_ex_type)
            && $stable(in_op) && $stable(in_tmask) && $stable(in_rd)
            && $stable(in_rs1) && $stable(in_rs2)))
        else begin
            assert_errors++;
            $error("in payload changed while in_ready was low");
        end

    out_idle_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            assert_errors++;
            $error("out_valid high during reset");
        end

endmodule

bind exec_core exec_core_properties props (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_uuid    (in_uuid),
    .in_ex_type (in_ex_type),
    .in_op      (in_op),
    .in_tmask   (in_tmask),
    .in_rd      (in_rd),
    .in_rs1     (in_rs1),
    .in_rs2     (in_rs2),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_uuid   (out_uuid),
    .out_rd     (out_rd),
    .out_tmask  (out_tmask),
    .out_data   (out_data)
);

`default_nettype wire

//--- exec_core.sv
// ****************************************
// Issue-to-writeback top level
// Latency 3 cycles without back-pressure
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module exec_core import gpu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    output logic       in_ready,
    input  wire uuid_t in_uuid,
    input  wire ex_type_e in_ex_type,
    input  wire op_e   in_op,
    input  wire tmask_t in_tmask,
    input  wire reg_t  in_rd,
    input  wire lane_vec_t in_rs1,
    input  wire lane_vec_t in_rs2,
    output logic       out_valid,
    input  wire        out_ready,
    output uuid_t      out_uuid,
    output reg_t       out_rd,
    output tmask_t     out_tmask,
    output lane_vec_t  out_data,
    output perf_ctr_t  perf_stalls_alu,
    output perf_ctr_t  perf_stalls_sfu
);

    // Dispatch to units
    logic      alu_valid, alu_ready, sfu_valid, sfu_ready;
    uuid_t     alu_uuid, sfu_uuid;
    op_e       alu_op, sfu_op;
    tmask_t    alu_tmask, sfu_tmask;
    reg_t      alu_rd, sfu_rd;
    lane_vec_t alu_rs1, alu_rs2, sfu_rs1, sfu_rs2;
    tid_t      sfu_last_tid;

    // Units to arbiter
    logic      alu_res_valid, alu_res_ready, sfu_res_valid, sfu_res_ready;
    uuid_t     alu_res_uuid, sfu_res_uuid;
    reg_t      alu_res_rd, sfu_res_rd;
    tmask_t    alu_res_tmask, sfu_res_tmask;
    lane_vec_t alu_res_data, sfu_res_data;

    dispatch dispatch (.*);

    alu_unit alu_unit (
        .clk (clk), .reset (reset),
        .alu_valid (alu_valid), .alu_ready (alu_ready), .alu_uuid (alu_uuid),
        .alu_op (alu_op), .alu_tmask (alu_tmask), .alu_rd (alu_rd),
        .alu_rs1 (alu_rs1), .alu_rs2 (alu_rs2),
        .res_valid (alu_res_valid), .res_ready (alu_res_ready), .res_uuid (alu_res_uuid),
        .res_rd (alu_res_rd), .res_tmask (alu_res_tmask), .res_data (alu_res_data)
    );

    sfu_unit sfu_unit (
        .clk (clk), .reset (reset),
        .sfu_valid (sfu_valid), .sfu_ready (sfu_ready), .sfu_uuid (sfu_uuid),
        .sfu_op (sfu_op), .sfu_tmask (sfu_tmask), .sfu_rd (sfu_rd),
        .sfu_rs1 (sfu_rs1), .sfu_rs2 (sfu_rs2), .sfu_last_tid (sfu_last_tid),
        .res_valid (sfu_res_valid), .res_ready (sfu_res_ready), .res_uuid (sfu_res_uuid),
        .res_rd (sfu_res_rd), .res_tmask (sfu_res_tmask), .res_data (sfu_res_data)
    );

    commit_arbiter commit_arbiter (.*);

endmodule

`default_nettype wire

//--- commit_arbiter.sv
// ****************************************
// Round-robin merge of ALU and SFU results
// Single registered writeback port
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module commit_arbiter import gpu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        alu_res_valid,
    output logic       alu_res_ready,
    input  wire uuid_t alu_res_uuid,
    input  wire reg_t  alu_res_rd,
    input  wire tmask_t alu_res_tmask,
    input  wire lane_vec_t alu_res_data,
    input  wire        sfu_res_valid,
    output logic       sfu_res_ready,
    input  wire uuid_t sfu_res_uuid,
    input  wire reg_t  sfu_res_rd,
    input  wire tmask_t sfu_res_tmask,
    input  wire lane_vec_t sfu_res_data,
    output logic       out_valid,
    input  wire        out_ready,
    output uuid_t      out_uuid,
    output reg_t       out_rd,
    output tmask_t     out_tmask,
    output lane_vec_t  out_data
);

    logic last_sfu;
    logic out_free;
    logic grant_sfu;
    logic take;

    assign out_free = !out_valid || out_ready;

    // On a tie the side that lost last time goes first
    assign grant_sfu = sfu_res_valid && (!alu_res_valid || !last_sfu);

    assign alu_res_ready = out_free && !grant_sfu;
    assign sfu_res_ready = out_free && grant_sfu;
    assign take = out_free && (alu_res_valid || sfu_res_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            last_sfu  <= 1'b0;
        end else if (out_free) begin
            out_valid <= alu_res_valid || sfu_res_valid;
            if (take) begin
                last_sfu <= grant_sfu;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_uuid  <= grant_sfu ? sfu_res_uuid : alu_res_uuid;
            out_rd    <= grant_sfu ? sfu_res_rd : alu_res_rd;
            out_tmask <= grant_sfu ? sfu_res_tmask : alu_res_tmask;
            out_data  <= grant_sfu ? sfu_res_data : alu_res_data;
        end
    end

endmodule

`default_nettype wire

//--- sfu_unit.sv
// ****************************************
// Cross-lane SFU ops, one register stage
// Result word is written to active lanes
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defs.svh"

module sfu_unit import gpu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        sfu_valid,
    output logic       sfu_ready,
    input  wire uuid_t sfu_uuid,
    input  wire op_e   sfu_op,
    input  wire tmask_t sfu_tmask,
    input  wire reg_t  sfu_rd,
    input  wire lane_vec_t sfu_rs1,
    input  wire lane_vec_t sfu_rs2,
    input  wire tid_t  sfu_last_tid,
    output logic       res_valid,
    input  wire        res_ready,
    output uuid_t      res_uuid,
    output reg_t       res_rd,
    output tmask_t     res_tmask,
    output lane_vec_t  res_data
);

    logic [`XLEN-1:0] popc;
    logic             any;
    logic [`XLEN-1:0] word;
    lane_vec_t        result;

    always_comb begin
        popc = '0;
        any  = 1'b0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            popc = popc + `XLEN'(sfu_tmask[i]);
            any  = any | (sfu_tmask[i] && (|sfu_rs1[i*`XLEN +: `XLEN]));
        end
        case (sfu_op)
            OP_BCAST_LAST: word = sfu_rs1[sfu_last_tid*`XLEN +: `XLEN];
            OP_POPC:       word = popc;
            OP_VOTE_ANY:   word = `XLEN'(any);
            default:       word = sfu_rs2[sfu_last_tid*`XLEN +: `XLEN];
        endcase
        for (int i = 0; i < `NUM_THREADS; i++) begin
            result[i*`XLEN +: `XLEN] = sfu_tmask[i] ? word : '0;
        end
    end

    assign sfu_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (sfu_ready) begin
            res_valid <= sfu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sfu_valid && sfu_ready) begin
            res_uuid  <= sfu_uuid;
            res_rd    <= sfu_rd;
            res_tmask <= sfu_tmask;
            res_data  <= result;
        end
    end

endmodule

`default_nettype wire

//--- alu_unit.sv
// ****************************************
// Per-lane integer ALU, one register stage
// Inactive lanes and unknown ops give 0
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defs.svh"

module alu_unit import gpu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        alu_valid,
    output logic       alu_ready,
    input  wire uuid_t alu_uuid,
    input  wire op_e   alu_op,
    input  wire tmask_t alu_tmask,
    input  wire reg_t  alu_rd,
    input  wire lane_vec_t alu_rs1,
    input  wire lane_vec_t alu_rs2,
    output logic       res_valid,
    input  wire        res_ready,
    output uuid_t      res_uuid,
    output reg_t       res_rd,
    output tmask_t     res_tmask,
    output lane_vec_t  res_data
);

    lane_vec_t result;

    always_comb begin
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] r;
        result = '0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            a = alu_rs1[i*`XLEN +: `XLEN];
            b = alu_rs2[i*`XLEN +: `XLEN];
            r = '0;
            case (alu_op)
                OP_ADD: r = a + b;
                OP_SUB: r = a - b;
                OP_AND: r = a & b;
                OP_OR:  r = a | b;
                OP_XOR: r = a ^ b;
                OP_SLT: r[0] = $signed(a) < $signed(b);
                default: r = '0;
            endcase
            if (alu_tmask[i]) begin
                result[i*`XLEN +: `XLEN] = r;
            end
        end
    end

    // Accept when the output slot is empty or draining
    assign alu_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (alu_ready) begin
            res_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid && alu_ready) begin
            res_uuid  <= alu_uuid;
            res_rd    <= alu_rd;
            res_tmask <= alu_tmask;
            res_data  <= result;
        end
    end

endmodule

`default_nettype wire

//--- dispatch.sv
// ****************************************
// Steers issued warps to ALU or SFU queue
// Empty thread mask yields last_tid 0
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defs.svh"

module dispatch import gpu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    output logic       in_ready,
    input  wire uuid_t in_uuid,
    input  wire ex_type_e in_ex_type,
    input  wire op_e   in_op,
    input  wire tmask_t in_tmask,
    input  wire reg_t  in_rd,
    input  wire lane_vec_t in_rs1,
    input  wire lane_vec_t in_rs2,
    output logic       alu_valid,
    input  wire        alu_ready,
    output uuid_t      alu_uuid,
    output op_e        alu_op,
    output tmask_t     alu_tmask,
    output reg_t       alu_rd,
    output lane_vec_t  alu_rs1,
    output lane_vec_t  alu_rs2,
    output logic       sfu_valid,
    input  wire        sfu_ready,
    output uuid_t      sfu_uuid,
    output op_e        sfu_op,
    output tmask_t     sfu_tmask,
    output reg_t       sfu_rd,
    output lane_vec_t  sfu_rs1,
    output lane_vec_t  sfu_rs2,
    output tid_t       sfu_last_tid,
    output perf_ctr_t  perf_stalls_alu,
    output perf_ctr_t  perf_stalls_sfu
);

    localparam int ALU_DW = $bits(uuid_t) + $bits(op_e) + $bits(tmask_t) + $bits(reg_t)
                          + 2 * $bits(lane_vec_t);
    localparam int SFU_DW = ALU_DW + $bits(tid_t);

    tid_t                    last_tid;
    logic                    alu_buf_ready;
    logic                    sfu_buf_ready;
    logic [ALU_DW-1:0]       alu_data;
    logic [SFU_DW-1:0]       sfu_data;
    logic [$bits(op_e)-1:0]  alu_op_bits;
    logic [$bits(op_e)-1:0]  sfu_op_bits;
    logic                    stall;

    // Highest active lane wins
    always_comb begin
        last_tid = '0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            if (in_tmask[i]) begin
                last_tid = tid_t'(i);
            end
        end
    end

    elastic_buffer #(.DATAW(ALU_DW)) alu_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (in_valid && (in_ex_type == EX_ALU)),
        .ready_in  (alu_buf_ready),
        .data_in   ({in_uuid, in_op, in_tmask, in_rd, in_rs1, in_rs2}),
        .valid_out (alu_valid),
        .data_out  (alu_data),
        .ready_out (alu_ready)
    );

    elastic_buffer #(.DATAW(SFU_DW)) sfu_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (in_valid && (in_ex_type == EX_SFU)),
        .ready_in  (sfu_buf_ready),
        .data_in   ({in_uuid, in_op, in_tmask, in_rd, in_rs1, in_rs2, last_tid}),
        .valid_out (sfu_valid),
        .data_out  (sfu_data),
        .ready_out (sfu_ready)
    );

    assign {alu_uuid, alu_op_bits, alu_tmask, alu_rd, alu_rs1, alu_rs2} = alu_data;
    assign alu_op = op_e'(alu_op_bits);
    assign {sfu_uuid, sfu_op_bits, sfu_tmask, sfu_rd, sfu_rs1, sfu_rs2, sfu_last_tid} = sfu_data;
    assign sfu_op = op_e'(sfu_op_bits);

    assign in_ready = (in_ex_type == EX_ALU) ? alu_buf_ready : sfu_buf_ready;

    // Stall cycles charged to the blocked unit type
    assign stall = in_valid && !in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_stalls_alu <= '0;
            perf_stalls_sfu <= '0;
        end else if (stall) begin
            if (in_ex_type == EX_ALU) begin
                perf_stalls_alu <= perf_stalls_alu + perf_ctr_t'(1);
            end else begin
                perf_stalls_sfu <= perf_stalls_sfu + perf_ctr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- elastic_buffer.sv
// ****************************************
// Two-entry valid/ready skid buffer
// Output and ready_in both come from flops
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              valid_in,
    output logic             ready_in,
    input  wire [DATAW-1:0]  data_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  wire              ready_out
);

    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             out_free;

    // Output slot can take a new beat this cycle
    assign out_free = !valid_out || ready_out;

    // Skid entry empty means one more beat fits
    assign ready_in = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            if (skid_valid) begin
                valid_out  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                valid_out <= valid_in;
            end
        end else if (valid_in && !skid_valid) begin
            // Downstream stalled, park the beat
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (!skid_valid) begin
            skid_data <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- gpu_pkg.sv
// ****************************************
// Shared types for the issue/execute slice
// SFU op names alias ALU encodings
// ****************************************

`default_nettype none

`include "gpu_defs.svh"

package gpu_pkg;

    typedef logic [`UUID_WIDTH-1:0]           uuid_t;
    typedef logic [`NUM_THREADS-1:0]          tmask_t;
    typedef logic [`NT_WIDTH-1:0]             tid_t;
    typedef logic [4:0]                       reg_t;
    // Lane i sits at bits i*XLEN upward
    typedef logic [`NUM_THREADS*`XLEN-1:0]    lane_vec_t;
    typedef logic [`PERF_CTR_BITS-1:0]        perf_ctr_t;

    typedef enum logic {
        EX_ALU = 1'b0,
        EX_SFU = 1'b1
    } ex_type_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5
    } op_e;

    // SFU decodes the same field under its own names
    localparam op_e OP_BCAST_LAST = OP_ADD;
    localparam op_e OP_POPC       = OP_SUB;
    localparam op_e OP_VOTE_ANY   = OP_AND;

endpackage

`default_nettype wire

//--- gpu_defs.svh
// ****************************************
// Warp geometry and counter widths
// NT_WIDTH must equal clog2(NUM_THREADS)
// ****************************************

`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

// Lanes per warp
`define NUM_THREADS 4

// Bits per lane
`define XLEN 32

`define NT_WIDTH 2

`define PERF_CTR_BITS 16

`define UUID_WIDTH 8

`endif
